//--- sim.f
huff_pkg.sv
huff_code_table.sv
huff_header_writer.sv
huff_encoder_ctrl.sv
huff_translation.sv
huff_bit_serializer.sv
huff_encoder_top.sv
tb_huff_encoder.sv

//--- Bender.yml
package:
  name: huff_encoder

sources:
  - huff_pkg.sv
  - huff_code_table.sv
  - huff_header_writer.sv
  - huff_encoder_ctrl.sv
  - huff_translation.sv
  - huff_bit_serializer.sv
  - huff_encoder_top.sv
  - target: simulation
    files:
      - tb_huff_encoder.sv

//--- tb_huff_encoder.sv
`timescale 1ns/1ns
`default_nettype none

module tb_huff_encoder;

    logic                 clk;
    logic                 rst;
    logic                 load_en;
    huff_pkg::code_load_t code_load;
    huff_pkg::char_t      entry_count;
    huff_pkg::count_t     tot_char;
    logic                 start;
    huff_pkg::char_t      char_in;
    logic                 next_char;
    huff_pkg::char_t      byte_out;
    logic                 byte_valid;
    logic                 done;

    logic [126:0]    leaf_val [0:127];               // Leaves of the code tree
    int              leaf_len [0:127];
    int              n_leaves;
    huff_pkg::char_t sym_char [0:15];
    logic [126:0]    sym_val  [0:15];
    int              sym_len  [0:15];
    int              n_sym;
    int              text_sym [$];                   // Symbol indices without the EOF
    huff_pkg::char_t exp_bytes [$];
    huff_pkg::char_t got_bytes [$];
    int              total_bits;

    huff_encoder_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "Mismatch in %s", what);
        end
    endtask

    function automatic huff_pkg::char_t char_at(input int idx);
        if (idx < text_sym.size()) return sym_char[text_sym[idx]];
        return huff_pkg::EOF_CHAR;
    endfunction

    // Splitting a leaf keeps the leaf set prefix free
    task automatic split_leaf(input int j);
        logic [126:0] v;
        int           r;
        v = leaf_val[j];
        r = $urandom % 2;
        leaf_val[j]        = (v << 1) | 127'(r);
        leaf_len[j]        = leaf_len[j] + 1;
        leaf_val[n_leaves] = (v << 1) | 127'(1 - r);
        leaf_len[n_leaves] = leaf_len[j];
        n_leaves++;
    endtask

    // Mode 0 random lengths up to 20, mode 1 long codes, mode 2 single-bit codes
    task automatic build_codes(input int mode);
        int j;
        int off;
        int lf;
        bit dup;
        leaf_val[0] = '0;
        leaf_len[0] = 1;
        leaf_val[1] = 127'd1;
        leaf_len[1] = 1;
        n_leaves    = 2;
        if (mode == 0) begin
            n_sym = 2 + $urandom % 11;
            repeat (19) split_leaf(n_leaves - 1);    // Depths 1 to 20
            repeat (8) begin
                j = $urandom % n_leaves;
                while (leaf_len[j] >= 20) j = $urandom % n_leaves;
                split_leaf(j);
            end
        end else if (mode == 1) begin
            n_sym = 2 + $urandom % 9;
            repeat (126) split_leaf(n_leaves - 1);   // Depths 1 to 127
        end else begin
            n_sym = 2;
        end
        off = $urandom % 127;
        for (int s = 0; s < n_sym; s++) begin
            if (mode == 0) lf = (off + s) % n_leaves;
            else if (mode == 2) lf = s;
            else if (s == 0) lf = 127;               // Always one 127 bit code
            else lf = (off + s - 1) % 127;
            sym_val[s] = leaf_val[lf];
            sym_len[s] = leaf_len[lf];
            dup = 1'b1;
            while (dup) begin
                sym_char[s] = 8'($urandom);
                dup = sym_char[s] == huff_pkg::EOF_CHAR;
                for (int k = 0; k < s; k++) begin
                    if (sym_char[k] == sym_char[s]) dup = 1'b1;
                end
            end
        end
    endtask

    task automatic build_text();
        int len;
        len = 5 + $urandom % 36;
        text_sym.delete();
        repeat (len) text_sym.push_back($urandom % n_sym);
        entry_count = 8'(n_sym);
        tot_char    = 32'(len + 1);                  // EOF counts as a character
    endtask

    task automatic build_expected();
        bit              bits [$];
        huff_pkg::char_t b;
        logic [15:0]     hdr;
        hdr = {huff_pkg::HEADER_MAGIC, entry_count};
        for (int i = 15; i >= 0; i--) bits.push_back(hdr[i]);
        for (int i = 31; i >= 0; i--) bits.push_back(tot_char[i]);
        foreach (text_sym[c]) begin
            for (int i = sym_len[text_sym[c]] - 1; i >= 0; i--) begin
                bits.push_back(sym_val[text_sym[c]][i]);
            end
        end
        total_bits = bits.size();
        exp_bytes.delete();
        while (bits.size() > 0) begin
            b = '0;                                  // Zero padding in the last byte
            for (int k = 7; k >= 0; k--) begin
                if (bits.size() > 0) b[k] = bits.pop_front();
            end
            exp_bytes.push_back(b);
        end
    endtask

    task automatic run_file(input int mode);
        int    idx;
        int    next_cnt;
        int    cycles;
        int    limit;
        bit    adv;
        string tag;
        rst = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        build_codes(mode);
        build_text();
        build_expected();
        for (int s = 0; s < n_sym; s++) begin
            load_en        = 1'b1;
            code_load.char = sym_char[s];
            code_load.path = (huff_pkg::path_t'(1) << sym_len[s]) |
                             huff_pkg::path_t'(sym_val[s]);
            @(negedge clk);
        end
        load_en = 1'b0;
        limit = total_bits * huff_pkg::SER_DIV
              + (text_sym.size() + 1) * (huff_pkg::TABLE_LAT + 2 * huff_pkg::SER_DIV + 4) + 64;
        idx      = 0;
        next_cnt = 0;
        cycles   = 0;
        adv      = 1'b0;
        got_bytes.delete();
        char_in = char_at(0);
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: done did not rise within %0d cycles", limit);
                $display("CHECKS FAILED");
                $fatal(1, "Run stopped by the cycle limit");
            end
            if (byte_valid) got_bytes.push_back(byte_out);
            if (adv) begin
                idx++;
                char_in = char_at(idx);              // One cycle after next_char
            end
            adv = next_char;
            if (next_char) next_cnt++;
        end
        check_value("byte count", got_bytes.size(), exp_bytes.size());
        foreach (exp_bytes[k]) begin
            if (k == 0) tag = "header magic";
            else if (k == 1) tag = "entry count";
            else if (k < 6) tag = $sformatf("count byte %0d", k - 2);
            else tag = $sformatf("code byte %0d", k);
            check_value(tag, got_bytes[k], exp_bytes[k]);
        end
        check_value("next_char pulses", next_cnt, text_sym.size() + 1);
        repeat (8 * huff_pkg::SER_DIV) begin
            @(negedge clk);
            check_value("byte_valid after done", byte_valid, 1'b0);
            check_value("done level", done, 1'b1);
        end
    endtask

    initial begin
        rst         = 1'b1;
        load_en     = 1'b0;
        code_load   = '0;
        entry_count = '0;
        tot_char    = '0;
        start       = 1'b0;
        char_in     = '0;
        void'($urandom(2));
        run_file(0);
        run_file(1);
        run_file(2);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- huff_encoder_top.sv
`timescale 1ns/1ns
`default_nettype none

module huff_encoder_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load_en,
    input  huff_pkg::code_load_t code_load,
    input  huff_pkg::char_t      entry_count,
    input  huff_pkg::count_t     tot_char,
    input  logic                 start,
    input  huff_pkg::char_t      char_in,
    output logic                 next_char,
    output huff_pkg::char_t      byte_out,
    output logic                 byte_valid,
    output logic                 done
);

    huff_pkg::en_state_t en_state;
    huff_pkg::path_t     path;
    huff_pkg::char_t     char_index;
    logic                ser_pulse;
    logic                head_bit;
    logic                head_write_en;
    logic                head_done;
    logic                pulse;                      // Lookup request
    logic                sram_complete;
    logic                write_bit;
    logic                input_valid;
    logic                fin_state;
    logic                flush;

    huff_encoder_ctrl u_ctrl (.*);

    huff_code_table u_code_table (.*);

    huff_header_writer u_header_writer (.*);

    huff_translation u_translation (.*);

    huff_bit_serializer u_bit_serializer (.*);

endmodule

`default_nettype wire

//--- huff_bit_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module huff_bit_serializer (
    input  logic                 clk,
    input  logic                 rst,
    input  huff_pkg::en_state_t  en_state,
    input  logic                 write_bit,
    input  logic                 input_valid,
    input  logic                 flush,
    output logic                 ser_pulse,
    output huff_pkg::char_t      byte_out,
    output logic                 byte_valid
);

    huff_pkg::slot_t slot_cnt;
    huff_pkg::char_t acc;                            // Pending bits in the low end
    logic [2:0]      bit_cnt;
    logic            active;

    assign active    = (en_state == huff_pkg::st_header) ||
                       (en_state == huff_pkg::st_translate);
    assign ser_pulse = active && (slot_cnt == huff_pkg::slot_t'(huff_pkg::SER_DIV - 1));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            slot_cnt <= '0;
        end else if (!active || ser_pulse) begin
            slot_cnt <= '0;
        end else begin
            slot_cnt <= slot_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (input_valid) begin
                bit_cnt <= bit_cnt + 1'b1;           // Wraps after a full byte
                if (bit_cnt == 3'd7) byte_valid <= 1'b1;
            end else if (flush) begin
                bit_cnt <= '0;
                if (bit_cnt != 3'd0) byte_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (input_valid) begin
            acc <= {acc[6:0], write_bit};
            if (bit_cnt == 3'd7) byte_out <= {acc[6:0], write_bit};
        end else if (flush && bit_cnt != 3'd0) begin
            byte_out <= acc << (4'd8 - {1'b0, bit_cnt});   // Zero pad the low bits
        end
    end

    a_valid_in_slot: assert property (@(posedge clk) disable iff (rst)
        input_valid |-> ser_pulse)
        else $error("Bit offered outside a bit slot");

endmodule

`default_nettype wire

//--- huff_translation.sv
`timescale 1ns/1ns
`default_nettype none

module huff_translation (
    input  logic                 clk,
    input  logic                 rst,
    input  huff_pkg::en_state_t  en_state,
    input  huff_pkg::count_t     tot_char,
    input  huff_pkg::char_t      char_in,
    input  huff_pkg::path_t      path,
    input  logic                 sram_complete,
    input  logic                 ser_pulse,
    input  logic                 head_bit,
    input  logic                 head_write_en,
    output logic                 write_bit,
    output logic                 next_char,
    output logic                 input_valid,
    output logic                 pulse,
    output logic                 fin_state,
    output huff_pkg::char_t      char_index
);

    typedef enum logic [2:0] {
        ph_count,                                    // Character count bits
        ph_lookup,                                   // Check char and request its path
        ph_wait,                                     // Table read in flight
        ph_send,                                     // Code bits below the sentinel
        ph_fin
    } phase_t;

    phase_t              phase;
    phase_t              phase_n;
    huff_pkg::path_idx_t bit_idx;
    huff_pkg::path_idx_t bit_idx_n;
    huff_pkg::path_idx_t top_pos;                    // Sentinel position
    logic                in_translate;

    assign char_index   = char_in;
    assign in_translate = en_state == huff_pkg::st_translate;

    // Highest set bit of the path marks where the code starts
    always_comb begin
        top_pos = '0;
        for (int i = 0; i < 128; i++) begin
            if (path[i]) top_pos = huff_pkg::path_idx_t'(i);
        end
    end

    always_comb begin
        phase_n     = phase;
        bit_idx_n   = bit_idx;
        write_bit   = 1'b0;
        input_valid = 1'b0;
        next_char   = 1'b0;
        pulse       = 1'b0;
        fin_state   = 1'b0;

        if (en_state == huff_pkg::st_header) begin
            if (ser_pulse && head_write_en) begin
                write_bit   = head_bit;              // Header bits pass straight through
                input_valid = 1'b1;
            end
        end else if (in_translate) begin
            case (phase)
                ph_count: begin
                    if (ser_pulse) begin
                        write_bit   = tot_char[bit_idx[4:0]];
                        input_valid = 1'b1;
                        bit_idx_n   = bit_idx - 1'b1;
                        if (bit_idx == '0) phase_n = ph_lookup;
                    end
                end
                ph_lookup: begin
                    next_char = 1'b1;                // EOF is consumed as well
                    if (char_in == huff_pkg::EOF_CHAR) begin
                        phase_n = ph_fin;
                    end else begin
                        pulse   = 1'b1;
                        phase_n = ph_wait;
                    end
                end
                ph_wait: begin
                    if (sram_complete) begin
                        bit_idx_n = top_pos - 1'b1;  // First bit below the sentinel
                        phase_n   = ph_send;
                    end
                end
                ph_send: begin
                    if (ser_pulse) begin
                        write_bit   = path[bit_idx];
                        input_valid = 1'b1;
                        bit_idx_n   = bit_idx - 1'b1;
                        if (bit_idx == '0) phase_n = ph_lookup;
                    end
                end
                ph_fin: fin_state = 1'b1;
                default: phase_n = ph_count;
            endcase
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            phase   <= ph_count;
            bit_idx <= 7'd31;
        end else if (in_translate) begin
            phase   <= phase_n;
            bit_idx <= bit_idx_n;
        end else begin
            phase   <= ph_count;                     // Rearm for the next file
            bit_idx <= 7'd31;
        end
    end

    a_fin_no_bit: assert property (@(posedge clk) disable iff (rst)
        !(fin_state && input_valid))
        else $error("Bit written while finishing");

    a_fin_to_done: assert property (@(posedge clk) disable iff (rst)
        fin_state |=> en_state == huff_pkg::st_done)
        else $error("Controller missed fin_state");

endmodule

`default_nettype wire

//--- huff_encoder_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module huff_encoder_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic                 head_done,
    input  logic                 fin_state,
    output huff_pkg::en_state_t  en_state,
    output logic                 flush,
    output logic                 done
);

    huff_pkg::en_state_t state_n;
    logic                flush_d;                    // Cycle of the last byte strobe

    always_comb begin
        state_n = en_state;
        case (en_state)
            huff_pkg::st_idle: begin
                if (start) state_n = huff_pkg::st_header;
            end
            huff_pkg::st_header: begin
                if (head_done) state_n = huff_pkg::st_translate;
            end
            huff_pkg::st_translate: begin
                if (fin_state) state_n = huff_pkg::st_done;
            end
            huff_pkg::st_done: begin
                if (start) state_n = huff_pkg::st_header;   // Next file
            end
            default: state_n = huff_pkg::st_idle;
        endcase
    end

    // done waits until the padded last byte has left the serializer
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            en_state <= huff_pkg::st_idle;
            flush    <= 1'b0;
            flush_d  <= 1'b0;
            done     <= 1'b0;
        end else begin
            en_state <= state_n;
            flush    <= (en_state == huff_pkg::st_translate) && fin_state;
            flush_d  <= flush;
            done     <= (state_n == huff_pkg::st_done) && (done || flush_d);
        end
    end

endmodule

`default_nettype wire

//--- huff_header_writer.sv
`timescale 1ns/1ns
`default_nettype none

module huff_header_writer (
    input  logic                 clk,
    input  logic                 rst,
    input  huff_pkg::en_state_t  en_state,
    input  logic                 ser_pulse,
    input  huff_pkg::char_t      entry_count,
    output logic                 head_bit,
    output logic                 head_write_en,
    output logic                 head_done
);

    logic [huff_pkg::HEADER_BITS-1:0] hdr_word;
    logic [4:0]                       hdr_cnt;       // Header bits already sent
    logic                             in_header;
    logic                             hdr_full;

    assign in_header = en_state == huff_pkg::st_header;
    assign hdr_word  = {huff_pkg::HEADER_MAGIC, entry_count};
    assign hdr_full  = hdr_cnt == 5'(huff_pkg::HEADER_BITS);

    assign head_write_en = in_header && ser_pulse && !hdr_full;
    assign head_bit      = hdr_word[4'(huff_pkg::HEADER_BITS - 1) - hdr_cnt[3:0]]; // MSB first
    assign head_done     = in_header && hdr_full;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hdr_cnt <= '0;
        end else if (!in_header) begin
            hdr_cnt <= '0;                           // Ready for the next file
        end else if (head_write_en) begin
            hdr_cnt <= hdr_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- huff_code_table.sv
`timescale 1ns/1ns
`default_nettype none

module huff_code_table (
    input  logic                   clk,
    input  logic                   rst,
    input  huff_pkg::en_state_t    en_state,
    input  logic                   load_en,
    input  huff_pkg::code_load_t   code_load,
    input  logic                   pulse,
    input  huff_pkg::char_t        char_index,
    output huff_pkg::path_t        path,
    output logic                   sram_complete
);

    huff_pkg::path_t code_mem [0:255];
    huff_pkg::char_t rd_addr;
    huff_pkg::lat_t  word_cnt;                       // Cycles left until the read lands

    always_ff @(posedge clk) begin
        if (load_en) begin
            code_mem[code_load.char] <= code_load.path;
        end
    end

    always_ff @(posedge clk) begin
        if (pulse) begin
            rd_addr <= char_index;                   // Latch before the host moves on
        end
        if (word_cnt == huff_pkg::lat_t'(1)) begin
            path <= code_mem[rd_addr];
        end
    end

    // sram_complete stays high until the next lookup request
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            word_cnt      <= '0;
            sram_complete <= 1'b0;
        end else if (pulse) begin
            word_cnt      <= huff_pkg::lat_t'(huff_pkg::TABLE_LAT - 1);
            sram_complete <= 1'b0;
        end else if (word_cnt != '0) begin
            word_cnt <= word_cnt - 1'b1;
            if (word_cnt == huff_pkg::lat_t'(1)) begin
                sram_complete <= 1'b1;
            end
        end
    end

    a_load_in_idle: assert property (@(posedge clk) disable iff (rst)
        load_en |-> en_state == huff_pkg::st_idle)
        else $error("Code table written while encoding");

endmodule

`default_nettype wire

//--- huff_pkg.sv
`default_nettype none

package huff_pkg;

    localparam int unsigned SER_DIV     = 4;         // Clocks per bit slot
    localparam int unsigned TABLE_LAT   = 2;         // Code table read latency
    localparam int unsigned HEADER_BITS = 16;        // Magic byte plus entry count
    localparam int unsigned SLOT_W      = $clog2(SER_DIV);
    localparam int unsigned LAT_W       = $clog2(TABLE_LAT) + 1;

    localparam logic [7:0] EOF_CHAR     = 8'h1A;     // End of file marker
    localparam logic [7:0] HEADER_MAGIC = 8'h48;     // First header byte

    typedef logic [7:0]        char_t;
    typedef logic [127:0]      path_t;               // Sentinel 1 above the code bits
    typedef logic [31:0]       count_t;
    typedef logic [6:0]        path_idx_t;           // Bit position inside a path
    typedef logic [SLOT_W-1:0] slot_t;
    typedef logic [LAT_W-1:0]  lat_t;

    // Header and translate are encoded as 4 and 5
    typedef enum logic [3:0] {
        st_idle      = 4'd0,
        st_header    = 4'd4,
        st_translate = 4'd5,
        st_done      = 4'd6
    } en_state_t;

    typedef struct packed {
        char_t char;                                 // Table index
        path_t path;                                 // Code path for that character
    } code_load_t;

endpackage

`default_nettype wire
